// File: vlog.f
+incdir+.
squeeze_pkg.sv
mac.sv
squeeze_kernel_rom.sv
squeeze_bias_rom.sv
squeeze_layer.sv
squeeze_ofm_buffer.sv
squeeze_top.sv
squeeze_checker.sv
squeeze_tb.sv

// File: Bender.yml
package:
  name: squeeze_stage

sources:
  - include_dirs:
      - .
    files:
      - squeeze_pkg.sv
      - mac.sv
      - squeeze_kernel_rom.sv
      - squeeze_bias_rom.sv
      - squeeze_layer.sv
      - squeeze_ofm_buffer.sv
      - squeeze_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - squeeze_checker.sv
      - squeeze_tb.sv

// File: squeeze_tb.sv
`timescale 1ns/1ns
`include "squeeze_macros.svh"

module squeeze_tb;
	import squeeze_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int OUTPUTS    = `SQ_WOUT * `SQ_WOUT;
	localparam int HOLD       = `SQ_TAPS + 16;
	// Three times the full layer plus room for reset and read back
	localparam int LIMIT      = OUTPUTS * `SQ_TAPS * 3 + 500;
	localparam logic [31:0] LFSR_MASK = 32'h8020_0003;

	logic clk;
	logic reset;
	logic layer_en;
	pix_t ifm;
	logic rd_en;
	buf_addr_t rd_addr;
	lane_pix_t rd_data;
	logic sample;
	logic finish;

	logic [31:0] lfsr = 32'h30dc_ff45;
	int errors = 0;
	int total;

	// Reference model state
	bit started = 1'b0;
	int tap_model = 0;
	int acc_model [`SQ_DSP_NO];
	lane_pix_t expected_q [$];
	// Model contents of the output buffer in write order
	lane_pix_t buffer_model [OUTPUTS];
	int sample_count = 0;

	squeeze_top squeeze_top_inst (
		.clk      (clk),
		.reset    (reset),
		.layer_en (layer_en),
		.ifm      (ifm),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.sample   (sample),
		.finish   (finish)
	);

	bind squeeze_top squeeze_checker squeeze_checker_inst (
		.clk          (clk),
		.reset        (reset),
		.rd_en        (rd_en),
		.sample       (sample),
		.finish       (finish),
		.ram_feedback (ram_feedback)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Random bits and model rules
	//////////////////////////////////////////////////////////////////////

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_MASK : 32'h0);
		end
		return v;
	endfunction

	function automatic int weight_of(input int l, input int k);
		return ((l * 37 + k * 11) % 64) - 32;
	endfunction

	function automatic int bias_of(input int l);
		return (l - 4) * 3 * (1 << `SQ_QSHIFT);
	endfunction

	// ReLU then bits 28..14 under a zero sign bit
	function automatic pix_t requant(input int sum);
		if (sum < 0) return '0;
		return pix_t'((sum >>> `SQ_QSHIFT) & 32'h7fff);
	endfunction

	// One enabled pixel into the model
	task automatic model_pixel(input pix_t pix);
		lane_pix_t bundle;
		if (!started) begin
			// First enabled cycle only takes the layer out of idle
			started = 1'b1;
		end else begin
			for (int l = 0; l < `SQ_DSP_NO; l++)
				acc_model[l] += int'(pix) * weight_of(l, tap_model);
			if (tap_model == `SQ_TAPS - 1) begin
				for (int l = 0; l < `SQ_DSP_NO; l++) begin
					bundle.lane[l] = requant(acc_model[l] + bias_of(l));
					acc_model[l] = 0;
				end
				expected_q.push_back(bundle);
				tap_model = 0;
			end else begin
				tap_model++;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus and checks
	//////////////////////////////////////////////////////////////////////

	// Pixel 0..255 with about one cycle in eight left as a gap
	task automatic drive_cycle(input bit hold_en);
		bit en;
		pix_t pix;
		@(negedge clk);
		en = hold_en || (take_bits(3) != 0);
		pix = pix_t'(take_bits(16) & 32'h0000_00ff);
		layer_en = en;
		ifm = pix;
		if (en) model_pixel(pix);
	endtask

	task automatic check_sample();
		lane_pix_t exp;
		lane_pix_t got;
		got = squeeze_top_inst.ofm;
		if (expected_q.size() == 0) begin
			$display("ERROR: sample at %0t with no expected output from the model", $time);
			errors++;
		end else begin
			exp = expected_q.pop_front();
			for (int l = 0; l < `SQ_DSP_NO; l++)
				assert (got.lane[l] == exp.lane[l]) else begin
					$display("CHECK FAILED at %0t: ofm.lane[%0d] expected %0d got %0d",
						$time, l, exp.lane[l], got.lane[l]);
					errors++;
				end
			if (sample_count < OUTPUTS) buffer_model[sample_count] = exp;
		end
		sample_count++;
	endtask

	// Samples checked where ofm is stable
	always @(negedge clk) begin
		if (!reset && sample) check_sample();
	end

	// Each address once with data one cycle after rd_en
	task automatic read_back();
		lane_pix_t got;
		for (int a = 0; a < OUTPUTS; a++) begin
			@(negedge clk);
			rd_en = 1'b1;
			rd_addr = buf_addr_t'(a);
			@(negedge clk);
			rd_en = 1'b0;
			got = rd_data;
			for (int l = 0; l < `SQ_DSP_NO; l++)
				assert (got.lane[l] == buffer_model[a].lane[l]) else begin
					$display("CHECK FAILED at %0t: rd_data[%0d].lane[%0d] expected %0d got %0d",
						$time, a, l, buffer_model[a].lane[l], got.lane[l]);
					errors++;
				end
		end
	endtask

	initial begin
		reset = 1'b1;
		layer_en = 1'b0;
		ifm = '0;
		rd_en = 1'b0;
		rd_addr = '0;
		for (int l = 0; l < `SQ_DSP_NO; l++) acc_model[l] = 0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		// Layer with gaps until the last output
		while (!finish) drive_cycle(1'b0);
		// Enable held high while the layer stays ended
		repeat (HOLD) drive_cycle(1'b1);
		@(negedge clk);
		layer_en = 1'b0;
		assert (sample_count == OUTPUTS) else begin
			$display("CHECK FAILED at %0t: sample count expected %0d got %0d",
				$time, OUTPUTS, sample_count);
			errors++;
		end
		read_back();
		repeat (8) @(negedge clk);
		assert (finish == 1'b0) else begin
			$display("CHECK FAILED at %0t: finish expected 0 got %0b", $time, finish);
			errors++;
		end
		total = errors + squeeze_top_inst.squeeze_checker_inst.fail_count;
		$display("Error counts: %0d data checks, %0d assertions", errors,
			squeeze_top_inst.squeeze_checker_inst.fail_count);
		if (total == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(LIMIT * CLK_PERIOD);
		$display("ERROR: timeout, run did not end within %0d cycles", LIMIT);
		$display("Test failures found");
		$finish;
	end

endmodule

// File: squeeze_checker.sv
`timescale 1ns/1ns
`include "squeeze_macros.svh"

module squeeze_checker (
	input logic clk,
	input logic reset,
	input logic rd_en,
	input logic sample,
	input logic finish,
	input logic ram_feedback
);
	localparam int OUTPUTS = `SQ_WOUT * `SQ_WOUT;

	// Failed assertion count
	int fail_count = 0;

	// Samples since reset
	int sample_cnt;
	// Feedback pulse already seen
	logic fb_seen;

	always_ff @(posedge clk) begin
		if (reset) begin
			sample_cnt <= 0;
			fb_seen    <= 1'b0;
		end else begin
			if (sample) sample_cnt <= sample_cnt + 1;
			if (ram_feedback) fb_seen <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reset and feedback
	//////////////////////////////////////////////////////////////////////

	// Strobes and finish come out of reset low
	reset_quiet: assert property (@(posedge clk)
		reset |=> (!sample && !finish && !ram_feedback))
		else begin
			$error("sample, finish or ram_feedback high right after reset");
			fail_count++;
		end

	// Feedback only follows a read, and only once
	fb_after_read: assert property (@(posedge clk) disable iff (reset)
		ram_feedback |-> ($past(rd_en) && !fb_seen))
		else begin
			$error("ram_feedback without a first read");
			fail_count++;
		end

	//////////////////////////////////////////////////////////////////////
	// Layer end and finish
	//////////////////////////////////////////////////////////////////////

	// No sample past the last output, none while finish is up
	sample_limit: assert property (@(posedge clk) disable iff (reset)
		sample |-> (sample_cnt < OUTPUTS && !finish))
		else begin
			$error("sample after the layer ended");
			fail_count++;
		end

	// Last sample raises finish
	finish_rise: assert property (@(posedge clk) disable iff (reset)
		(sample && sample_cnt == OUTPUTS - 1) |=> finish)
		else begin
			$error("finish did not rise after the last sample");
			fail_count++;
		end

	// finish only with every output stored
	finish_full: assert property (@(posedge clk) disable iff (reset)
		finish |-> (sample_cnt == OUTPUTS))
		else begin
			$error("finish high before all outputs were sampled");
			fail_count++;
		end

	// First read drops finish for good
	finish_low: assert property (@(posedge clk) disable iff (reset)
		(ram_feedback || fb_seen) |=> !finish)
		else begin
			$error("finish still high after the first buffer read");
			fail_count++;
		end

endmodule

// File: squeeze_top.sv
`timescale 1ns/1ns

module squeeze_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   layer_en,
	input  squeeze_pkg::pix_t      ifm,
	input  logic                   rd_en,
	input  squeeze_pkg::buf_addr_t rd_addr,
	output squeeze_pkg::lane_pix_t rd_data,
	output logic                   sample,
	output logic                   finish
);
	import squeeze_pkg::*;

	// Internal links
	tap_t tap;
	lane_pix_t kernels;
	lane_acc_t bias;
	lane_pix_t ofm;
	logic ram_feedback;

	//////////////////////////////////////////////////////////////////////
	// Layer with its weight and bias sources
	//////////////////////////////////////////////////////////////////////

	squeeze_layer squeeze_layer_inst (
		.clk          (clk),
		.reset        (reset),
		.layer_en     (layer_en),
		.ifm          (ifm),
		.kernels      (kernels),
		.bias         (bias),
		.ram_feedback (ram_feedback),
		.tap          (tap),
		.ofm          (ofm),
		.sample       (sample),
		.finish       (finish)
	);

	squeeze_kernel_rom squeeze_kernel_rom_inst (
		.clk     (clk),
		.reset   (reset),
		.tap     (tap),
		.kernels (kernels)
	);

	squeeze_bias_rom squeeze_bias_rom_inst (
		.bias (bias)
	);

	// Output store, read back by the consumer
	squeeze_ofm_buffer squeeze_ofm_buffer_inst (
		.clk          (clk),
		.reset        (reset),
		.wr_en        (sample),
		.wr_data      (ofm),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.ram_feedback (ram_feedback)
	);

endmodule

// File: squeeze_ofm_buffer.sv
`timescale 1ns/1ns
`include "squeeze_macros.svh"

module squeeze_ofm_buffer (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   wr_en,
	input  squeeze_pkg::lane_pix_t wr_data,
	input  logic                   rd_en,
	input  squeeze_pkg::buf_addr_t rd_addr,
	output squeeze_pkg::lane_pix_t rd_data,
	output logic                   ram_feedback
);
	import squeeze_pkg::*;

	// One bundle per output pixel
	lane_pix_t mem [`SQ_WOUT*`SQ_WOUT];

	buf_addr_t wr_ptr;
	logic rd_seen;

	//////////////////////////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////////////////////////

	// Storage
	always_ff @(posedge clk) begin
		if (wr_en) mem[wr_ptr] <= wr_data;
	end

	// Next free slot, steps once per sample
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
		end else if (wr_en) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read side and feedback
	//////////////////////////////////////////////////////////////////////

	// Data one cycle after rd_en
	always_ff @(posedge clk) begin
		if (rd_en) rd_data <= mem[rd_addr];
	end

	// Single pulse on the first read since reset
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_seen      <= 1'b0;
			ram_feedback <= 1'b0;
		end else begin
			ram_feedback <= rd_en && !rd_seen;
			if (rd_en) rd_seen <= 1'b1;
		end
	end

endmodule

// File: squeeze_layer.sv
`timescale 1ns/1ns
`include "squeeze_macros.svh"

module squeeze_layer (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   layer_en,
	input  squeeze_pkg::pix_t      ifm,
	input  squeeze_pkg::lane_pix_t kernels,
	input  squeeze_pkg::lane_acc_t bias,
	input  logic                   ram_feedback,
	output squeeze_pkg::tap_t      tap,
	output squeeze_pkg::lane_pix_t ofm,
	output logic                   sample,
	output logic                   finish
);
	import squeeze_pkg::*;

	layer_state_t state;
	logic count_en;

	// Pixel register, same latency as the kernel ROM
	pix_t ifm_q;

	// Window clear delay line
	logic rom_clr;
	logic temp_clr_pulse;
	logic clr_pulse;

	// Enable delay line, runs beside the clear
	logic en_q;
	logic en_d;
	logic en_mac;

	// Output capture
	logic clr_seen;
	logic capture;
	out_idx_t out_cnt;
	logic fb_seen;

	wire lane_acc_t lane_acc;
	lane_acc_t biased;

	//////////////////////////////////////////////////////////////////////
	// State and tap counter
	//////////////////////////////////////////////////////////////////////

	// A tap is taken only while running and enabled
	assign count_en = layer_en && (state == run);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle: if (layer_en) state <= run;
				// Last of WOUT^2 samples ends the layer
				run: if (sample && out_cnt == out_idx_t'(`SQ_WOUT * `SQ_WOUT - 1)) state <= done;
				done: state <= done;
				default: state <= idle;
			endcase
		end
	end

	// Wraps after the last tap of a window, holds in gaps
	always_ff @(posedge clk) begin
		if (reset) begin
			tap <= '0;
		end else if (count_en) begin
			if (tap == tap_t'(`SQ_TAPS - 1)) begin
				tap <= '0;
			end else begin
				tap <= tap + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Clear pulse alignment
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		ifm_q <= ifm;
	end

	// rom_clr lines up with ifm_q and the ROM output,
	// two more stages cover the operand and product registers in mac
	always_ff @(posedge clk) begin
		if (reset) begin
			rom_clr        <= 1'b0;
			temp_clr_pulse <= 1'b0;
			clr_pulse      <= 1'b0;
			en_q           <= 1'b0;
			en_d           <= 1'b0;
			en_mac         <= 1'b0;
		end else begin
			rom_clr        <= count_en && (tap == '0);
			temp_clr_pulse <= rom_clr;
			clr_pulse      <= temp_clr_pulse;
			en_q           <= count_en;
			en_d           <= en_q;
			en_mac         <= en_d;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// MAC array
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `SQ_DSP_NO; i++) begin : g_mac
		mac mac_inst (
			.clk   (clk),
			.reset (reset),
			.clr   (clr_pulse),
			.en    (en_mac),
			.pix   (ifm_q),
			.ker   (kernels.lane[i]),
			.acc   (lane_acc.lane[i])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Bias, ReLU and requantization
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int l = 0; l < `SQ_DSP_NO; l++) begin
			biased.lane[l] = lane_acc.lane[l] + bias.lane[l];
		end
	end

	// The first clear after reset opens window 0 and has no sum behind it
	assign capture = clr_pulse && clr_seen && (state == run);

	always_ff @(posedge clk) begin
		if (capture) begin
			for (int l = 0; l < `SQ_DSP_NO; l++) begin
				// Negative sum clips to zero
				if (biased.lane[l][$bits(acc_t)-1]) begin
					ofm.lane[l] <= '0;
				end else begin
					ofm.lane[l] <= {1'b0,
						biased.lane[l][`SQ_QSHIFT+`SQ_WIDTH-2 -: `SQ_WIDTH-1]};
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sample, layer end and finish
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			clr_seen <= 1'b0;
			sample   <= 1'b0;
			out_cnt  <= '0;
			fb_seen  <= 1'b0;
		end else begin
			if (clr_pulse) clr_seen <= 1'b1;
			// Sample trails the ofm update by one cycle
			sample <= capture;
			if (sample) out_cnt <= out_cnt + 1'b1;
			// Consumer has started reading the buffer
			if (ram_feedback) fb_seen <= 1'b1;
		end
	end

	assign finish = (state == done) && !fb_seen;

endmodule

// File: squeeze_bias_rom.sv
`timescale 1ns/1ns
`include "squeeze_macros.svh"

module squeeze_bias_rom (
	output squeeze_pkg::lane_acc_t bias
);
	import squeeze_pkg::*;

	// Bias rule constants
	// Lanes below the centre get a negative bias
	localparam int CENTER = 4;
	localparam int STEP   = 3;

	// Biases sit at the accumulator scale
	// One unit of output is 2^QSHIFT in the sum
	localparam int UNIT = 1 << `SQ_QSHIFT;

	//////////////////////////////////////////////////////////////////////
	// Constant per-lane table
	//////////////////////////////////////////////////////////////////////

	// Stands in for learned biases
	// A trained table drops in here unchanged
	always_comb begin
		for (int l = 0; l < `SQ_DSP_NO; l++) begin
			bias.lane[l] = acc_t'((l - CENTER) * STEP * UNIT);
		end
	end

endmodule

// File: squeeze_kernel_rom.sv
`timescale 1ns/1ns
`include "squeeze_macros.svh"

module squeeze_kernel_rom (
	input  logic                   clk,
	input  logic                   reset,
	input  squeeze_pkg::tap_t      tap,
	output squeeze_pkg::lane_pix_t kernels
);
	import squeeze_pkg::*;

	// Weight rule constants
	localparam int LANE_MUL = 37;
	localparam int TAP_MUL  = 11;
	localparam int WRAP     = 64;
	localparam int OFFSET   = 32;

	//////////////////////////////////////////////////////////////////////
	// Weight table, one lane bundle per tap
	//////////////////////////////////////////////////////////////////////

	wire lane_pix_t rom_table [`SQ_TAPS];

	for (genvar k = 0; k < `SQ_TAPS; k++) begin : g_tap
		for (genvar l = 0; l < `SQ_DSP_NO; l++) begin : g_lane
			// Spread of small signed weights, range -32 to 31
			assign rom_table[k].lane[l] =
				pix_t'(((l * LANE_MUL + k * TAP_MUL) % WRAP) - OFFSET);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registered read
	//////////////////////////////////////////////////////////////////////

	// One cycle latency
	// Matches the registered pixel inside the layer
	always_ff @(posedge clk) begin
		if (reset) begin
			kernels <= '0;
		end else begin
			kernels <= rom_table[tap];
		end
	end

endmodule

// File: mac.sv
`timescale 1ns/1ns

module mac (
	input  logic              clk,
	input  logic              reset,
	input  logic              clr,
	input  logic              en,
	input  squeeze_pkg::pix_t pix,
	input  squeeze_pkg::pix_t ker,
	output squeeze_pkg::acc_t acc
);
	import squeeze_pkg::*;

	// Operand stage, lines the operands up with the clear delay line
	pix_t pix_q;
	pix_t ker_q;
	// Product stage
	acc_t prod;

	// Operands and product flow every cycle, en qualifies them at the end
	always_ff @(posedge clk) begin
		pix_q <= pix;
		ker_q <= ker;
		// Signed 16x16 product, sign extended to accumulator width
		prod <= pix_q * ker_q;
	end

	// Accumulator
	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
		end else if (clr) begin
			// First product of a new window replaces the old sum
			acc <= prod;
		end else if (en) begin
			acc <= acc + prod;
		end
	end

endmodule

// File: squeeze_pkg.sv
`include "squeeze_macros.svh"

package squeeze_pkg;

	//////////////////////////////////////////////////////////////////////
	// Scalar types
	//////////////////////////////////////////////////////////////////////

	// Signed pixel or weight
	typedef logic signed [`SQ_WIDTH-1:0] pix_t;

	// Signed accumulator, twice the pixel width
	typedef logic signed [2*`SQ_WIDTH-1:0] acc_t;

	// Tap index inside one window
	typedef logic [$clog2(`SQ_TAPS)-1:0] tap_t;

	// Finished output count, one spare bit so the full count fits
	typedef logic [$clog2(`SQ_WOUT*`SQ_WOUT):0] out_idx_t;

	// Output buffer address
	typedef logic [$clog2(`SQ_WOUT*`SQ_WOUT)-1:0] buf_addr_t;

	//////////////////////////////////////////////////////////////////////
	// Lane bundles
	//////////////////////////////////////////////////////////////////////

	// One pixel per lane, used for weights and outputs
	typedef struct packed {
		pix_t [`SQ_DSP_NO-1:0] lane;
	} lane_pix_t;

	// One accumulator per lane, used for sums and biases
	typedef struct packed {
		acc_t [`SQ_DSP_NO-1:0] lane;
	} lane_acc_t;

	// Layer controller states
	typedef enum logic [1:0] {
		idle,
		run,
		done
	} layer_state_t;

endpackage

// File: squeeze_macros.svh
`ifndef SQUEEZE_MACROS_SVH
`define SQUEEZE_MACROS_SVH

// MAC lanes working side by side on the shared pixel stream
`define SQ_DSP_NO 8

// Input feature map channels
`define SQ_CHIN 16

// Square kernel side
`define SQ_KERNEL_DIM 3

// Products summed per output pixel of one lane
`define SQ_TAPS (`SQ_KERNEL_DIM * `SQ_KERNEL_DIM * `SQ_CHIN)

// Output map side, WOUT squared outputs per layer
`define SQ_WOUT 4

// Pixel and weight width
`define SQ_WIDTH 16

// Fixed point shift applied at requantization
`define SQ_QSHIFT 14

`endif
